// File: gtePkg.sv
// Shared definitions for the coprocessor data register file
// Register numbers, word widths and the two views of a CPU word
package gtePkg;

	// ------------------------------------------------------------------------
	// Widths
	// ------------------------------------------------------------------------
	localparam int WordBits  = 32;   // CPU bus word
	localparam int HalfBits  = 16;   // One coordinate or IR value
	localparam int ColorBits = 5;    // One 5:5:5 channel
	localparam int CountBits = 6;    // Leading count, 1..32

	// Data register numbers seen by the CPU
	typedef enum logic [4:0] {
		RegVxy0 = 5'd0,
		RegVz0  = 5'd1,
		RegVxy1 = 5'd2,
		RegVz1  = 5'd3,
		RegVxy2 = 5'd4,
		RegVz2  = 5'd5,
		RegIr1  = 5'd9,
		RegIr2  = 5'd10,
		RegIr3  = 5'd11,
		RegSxy0 = 5'd12,
		RegSxy1 = 5'd13,
		RegSxy2 = 5'd14,
		RegSxyP = 5'd15,   // Push into screen FIFO
		RegIrgb = 5'd28,
		RegOrgb = 5'd29,   // Read only
		RegLzcs = 5'd30,
		RegLzcr = 5'd31    // Read only
	} regId_t;

	typedef logic signed [HalfBits-1:0] half_t;

	// Packed colour, red in the low bits
	typedef struct packed {
		logic [WordBits-3*ColorBits-1:0] unused;
		logic [ColorBits-1:0]            b;
		logic [ColorBits-1:0]            g;
		logic [ColorBits-1:0]            r;
	} rgb15_t;

	typedef struct packed {
		half_t y;   // High half
		half_t x;   // Low half
	} xyPair_t;

	// Same CPU word seen as coordinates or as colour
	typedef union packed {
		xyPair_t xy;
		rgb15_t  rgb;
	} gteWord_t;

	typedef logic [CountBits-1:0] count_t;

endpackage

// File: gteWriteDecode.sv
// Write decoder of the data register file
// Turns the CPU strobe and register number into one enable per register
`timescale 1ns/1ps

module gteWriteDecode (
	input  logic           i_writeReg,
	input  gtePkg::regId_t i_regId,
	output logic [2:0]     o_wrVxy,
	output logic [2:0]     o_wrVz,
	output logic [2:0]     o_wrSxy,
	output logic           o_pushSxy,
	output logic [2:0]     o_wrIr,
	output logic           o_wrIrgb,
	output logic           o_wrLzcs
);
	import gtePkg::*;

	// ------------------------------------------------------------------------
	// Input vectors
	// ------------------------------------------------------------------------
	assign o_wrVxy[0] = i_writeReg & (i_regId == RegVxy0);
	assign o_wrVxy[1] = i_writeReg & (i_regId == RegVxy1);
	assign o_wrVxy[2] = i_writeReg & (i_regId == RegVxy2);
	assign o_wrVz[0]  = i_writeReg & (i_regId == RegVz0);   // Z from low half
	assign o_wrVz[1]  = i_writeReg & (i_regId == RegVz1);
	assign o_wrVz[2]  = i_writeReg & (i_regId == RegVz2);

	// Screen FIFO, direct entries and push
	assign o_wrSxy[0] = i_writeReg & (i_regId == RegSxy0);
	assign o_wrSxy[1] = i_writeReg & (i_regId == RegSxy1);
	assign o_wrSxy[2] = i_writeReg & (i_regId == RegSxy2);
	assign o_pushSxy  = i_writeReg & (i_regId == RegSxyP);  // Never with a direct write

	// ------------------------------------------------------------------------
	// IR and lead counter
	// ------------------------------------------------------------------------
	assign o_wrIr[0]  = i_writeReg & (i_regId == RegIr1);
	assign o_wrIr[1]  = i_writeReg & (i_regId == RegIr2);
	assign o_wrIr[2]  = i_writeReg & (i_regId == RegIr3);
	assign o_wrIrgb   = i_writeReg & (i_regId == RegIrgb);  // Loads all three IR

	// ORGB and LZCR are read only and have no enable
	assign o_wrLzcs   = i_writeReg & (i_regId == RegLzcs);

endmodule

// File: gteVectorRegs.sv
// Input vector storage V0..V2
// XY written as one word, Z from the low half of its own write
`timescale 1ns/1ps

module gteVectorRegs (
	input  logic              i_clk,
	input  logic              i_rstN,
	input  logic [2:0]        i_wrVxy,
	input  logic [2:0]        i_wrVz,
	input  gtePkg::gteWord_t  i_dataIn,
	output gtePkg::xyPair_t   o_vxy [3],
	output gtePkg::half_t     o_vz  [3]
);
	import gtePkg::*;

	// ------------------------------------------------------------------------
	// Vector registers
	// ------------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_rstN) begin
			for (int i = 0; i < 3; i++) begin
				o_vxy[i] <= '0;
				o_vz[i]  <= '0;
			end
		end else begin
			for (int i = 0; i < 3; i++) begin
				// Y from the high half, X from the low half
				if (i_wrVxy[i])
					o_vxy[i] <= i_dataIn.xy;
				if (i_wrVz[i])
					o_vz[i] <= i_dataIn.xy.x;   // Upper half ignored
			end
		end
	end

endmodule

// File: gteScreenFifo.sv
// Three-entry screen XY FIFO
// Entries are written directly or shifted down by a push through SXYP
`timescale 1ns/1ps

module gteScreenFifo (
	input  logic             i_clk,
	input  logic             i_rstN,
	input  logic [2:0]       i_wrSxy,
	input  logic             i_pushSxy,
	input  gtePkg::gteWord_t i_dataIn,
	output gtePkg::xyPair_t  o_sxy [3]
);
	import gtePkg::*;

	xyPair_t sxyReg [3];    // Entry 2 is the newest

	// ------------------------------------------------------------------------
	// FIFO update
	// ------------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_rstN) begin
			for (int i = 0; i < 3; i++)
				sxyReg[i] <= '0;
		end else if (i_pushSxy) begin
			// Oldest entry drops out
			sxyReg[0] <= sxyReg[1];
			sxyReg[1] <= sxyReg[2];
			sxyReg[2] <= i_dataIn.xy;
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (i_wrSxy[i])
					sxyReg[i] <= i_dataIn.xy;   // Direct replace
			end
		end
	end

	assign o_sxy = sxyReg;

endmodule

// File: gteIrRegs.sv
// IR1..IR3 storage with the packed colour write and saturated readback
// IRGB expands 5:5:5 into the IR registers, o_rgb squeezes them back
`timescale 1ns/1ps

module gteIrRegs (
	input  logic             i_clk,
	input  logic             i_rstN,
	input  logic [2:0]       i_wrIr,
	input  logic             i_wrIrgb,
	input  gtePkg::gteWord_t i_dataIn,
	output gtePkg::half_t    o_ir [3],
	output gtePkg::rgb15_t   o_rgb
);
	import gtePkg::*;

	localparam int    ChanShift = 7;             // Channel sits at IR bits 11..7
	localparam half_t SatLimit  = 16'sh0F80;     // First value that clips to 31

	half_t irReg [3];

	// Channel into IR position, zeros elsewhere
	function automatic half_t expandChan(input logic [ColorBits-1:0] c);
		return {{(HalfBits-ColorBits-ChanShift){1'b0}}, c, {ChanShift{1'b0}}};
	endfunction

	// IR back to a 5-bit channel
	function automatic logic [ColorBits-1:0] satChan(input half_t v);
		if (v < 0)
			return '0;                           // Negative clips to black
		else if (v >= SatLimit)
			return '1;                           // Full scale
		return v[ChanShift+ColorBits-1:ChanShift];
	endfunction

	// ------------------------------------------------------------------------
	// Registers
	// ------------------------------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_rstN) begin
			for (int i = 0; i < 3; i++)
				irReg[i] <= '0;
		end else if (i_wrIrgb) begin
			irReg[0] <= expandChan(i_dataIn.rgb.r);   // IR1
			irReg[1] <= expandChan(i_dataIn.rgb.g);   // IR2
			irReg[2] <= expandChan(i_dataIn.rgb.b);   // IR3
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (i_wrIr[i])
					irReg[i] <= i_dataIn.xy.x;
			end
		end
	end

	assign o_ir = irReg;

	// Saturated colour, shared by IRGB and ORGB reads
	always_comb begin
		o_rgb   = '0;
		o_rgb.r = satChan(irReg[0]);
		o_rgb.g = satChan(irReg[1]);
		o_rgb.b = satChan(irReg[2]);
	end

endmodule

// File: gteLeadCount.sv
// Leading sign-bit counter
// Holds LZCS and counts its leading bits equal to the sign, 1..WordWidth
`timescale 1ns/1ps

module gteLeadCount #(
	parameter int WordWidth = 32
) (
	input  logic             i_clk,
	input  logic             i_rstN,
	input  logic             i_wrLzcs,
	input  gtePkg::gteWord_t i_dataIn,
	output gtePkg::gteWord_t o_lzcs,
	output gtePkg::count_t   o_count
);
	import gtePkg::*;

	logic [WordWidth-1:0] lzcsReg;
	logic                 hitDiff;   // First bit unlike the sign seen
	count_t               leadCnt;

	always_ff @(posedge i_clk) begin
		if (!i_rstN)
			lzcsReg <= '0;
		else if (i_wrLzcs)
			lzcsReg <= i_dataIn;
	end

	// ------------------------------------------------------------------------
	// Count from the MSB, sign bit itself counts as one
	// ------------------------------------------------------------------------
	always_comb begin
		hitDiff = 1'b0;
		leadCnt = count_t'(1);
		for (int i = WordWidth - 2; i >= 0; i--) begin
			if (lzcsReg[i] != lzcsReg[WordWidth-1])
				hitDiff = 1'b1;
			if (!hitDiff)
				leadCnt = leadCnt + 1'b1;   // Zero and all-ones reach WordWidth
		end
	end

	assign o_lzcs  = lzcsReg;
	assign o_count = leadCnt;

endmodule

// File: gteReadMux.sv
// CPU read multiplexer of the data register file
// Purely combinational from the register number and current contents
`timescale 1ns/1ps

module gteReadMux (
	input  gtePkg::regId_t   i_regId,
	input  gtePkg::xyPair_t  i_vxy [3],
	input  gtePkg::half_t    i_vz  [3],
	input  gtePkg::xyPair_t  i_sxy [3],
	input  gtePkg::half_t    i_ir  [3],
	input  gtePkg::rgb15_t   i_rgb,
	input  gtePkg::gteWord_t i_lzcs,
	input  gtePkg::count_t   i_count,
	output gtePkg::gteWord_t o_dataOut
);
	import gtePkg::*;

	// Signed 16-bit value to a full word
	function automatic gteWord_t sext(input half_t v);
		return {{(WordBits-HalfBits){v[HalfBits-1]}}, v};
	endfunction

	// ------------------------------------------------------------------------
	// Read select
	// ------------------------------------------------------------------------
	always_comb begin
		o_dataOut = '0;   // Unlisted numbers read zero
		case (i_regId)
			RegVxy0 : o_dataOut.xy = i_vxy[0];
			RegVz0  : o_dataOut    = sext(i_vz[0]);
			RegVxy1 : o_dataOut.xy = i_vxy[1];
			RegVz1  : o_dataOut    = sext(i_vz[1]);
			RegVxy2 : o_dataOut.xy = i_vxy[2];
			RegVz2  : o_dataOut    = sext(i_vz[2]);
			RegIr1  : o_dataOut    = sext(i_ir[0]);
			RegIr2  : o_dataOut    = sext(i_ir[1]);
			RegIr3  : o_dataOut    = sext(i_ir[2]);
			RegSxy0 : o_dataOut.xy = i_sxy[0];
			RegSxy1 : o_dataOut.xy = i_sxy[1];
			RegSxy2,
			RegSxyP : o_dataOut.xy = i_sxy[2];   // SXYP mirrors newest entry
			RegIrgb,
			RegOrgb : begin
				// Colour zero-extended, high bits stay clear
				o_dataOut.rgb.r = i_rgb.r;
				o_dataOut.rgb.g = i_rgb.g;
				o_dataOut.rgb.b = i_rgb.b;
			end
			RegLzcs : o_dataOut    = i_lzcs;
			RegLzcr : o_dataOut    = WordBits'(i_count);
			default : o_dataOut    = '0;
		endcase
	end

endmodule

// File: gteRegFile.sv
// Top of the CPU-side data register file
// Write strobe and register number in, combinational read word out
`timescale 1ns/1ps

module gteRegFile (
	input  logic             i_clk,
	input  logic             i_rstN,
	input  logic             i_writeReg,
	input  gtePkg::regId_t   i_regId,
	input  gtePkg::gteWord_t i_dataIn,
	output gtePkg::gteWord_t o_dataOut
);
	import gtePkg::*;

	// Write enables
	logic [2:0] wrVxy, wrVz, wrSxy, wrIr;
	logic       pushSxy, wrIrgb, wrLzcs;

	// Register contents towards the read side
	xyPair_t    vxy [3];
	half_t      vz  [3];
	xyPair_t    sxy [3];
	half_t      ir  [3];
	rgb15_t     rgb;
	gteWord_t   lzcs;
	count_t     leadCount;

	// ------------------------------------------------------------------------
	// Input side
	// ------------------------------------------------------------------------
	gteWriteDecode gteWriteDecode_inst (
		.i_writeReg(i_writeReg), .i_regId(i_regId),
		.o_wrVxy(wrVxy), .o_wrVz(wrVz), .o_wrSxy(wrSxy), .o_pushSxy(pushSxy),
		.o_wrIr(wrIr), .o_wrIrgb(wrIrgb), .o_wrLzcs(wrLzcs)
	);

	// Storage
	gteVectorRegs gteVectorRegs_inst (
		.i_clk(i_clk), .i_rstN(i_rstN), .i_wrVxy(wrVxy), .i_wrVz(wrVz),
		.i_dataIn(i_dataIn), .o_vxy(vxy), .o_vz(vz)
	);
	gteScreenFifo gteScreenFifo_inst (
		.i_clk(i_clk), .i_rstN(i_rstN), .i_wrSxy(wrSxy), .i_pushSxy(pushSxy),
		.i_dataIn(i_dataIn), .o_sxy(sxy)
	);
	gteIrRegs gteIrRegs_inst (
		.i_clk(i_clk), .i_rstN(i_rstN), .i_wrIr(wrIr), .i_wrIrgb(wrIrgb),
		.i_dataIn(i_dataIn), .o_ir(ir), .o_rgb(rgb)
	);
	gteLeadCount #(.WordWidth(WordBits)) gteLeadCount_inst (
		.i_clk(i_clk), .i_rstN(i_rstN), .i_wrLzcs(wrLzcs),
		.i_dataIn(i_dataIn), .o_lzcs(lzcs), .o_count(leadCount)
	);

	// ------------------------------------------------------------------------
	// Output side
	// ------------------------------------------------------------------------
	gteReadMux gteReadMux_inst (
		.i_regId(i_regId), .i_vxy(vxy), .i_vz(vz), .i_sxy(sxy), .i_ir(ir),
		.i_rgb(rgb), .i_lzcs(lzcs), .i_count(leadCount), .o_dataOut(o_dataOut)
	);

endmodule

// File: gteRegFile_sva.sv
// Concurrent checks on the screen FIFO push and on zero reads of unlisted numbers
// Bound into the register file top, where FIFO contents and the read word meet
`timescale 1ns/1ps

module gteRegFile_sva (
	input logic             i_clk,
	input logic             i_rstN,
	input logic             i_pushSxy,
	input gtePkg::xyPair_t  i_sxy [3],
	input gtePkg::regId_t   i_regId,
	input gtePkg::gteWord_t i_dataOut
);
	import gtePkg::*;

	logic assertFail = 1'b0;   // Latched on any assertion failure

	// Old newest entry moves down one place
	pushShift: assert property (@(posedge i_clk) disable iff (!i_rstN)
		i_pushSxy |=> (i_sxy[1] == $past(i_sxy[2])))
		else begin
			assertFail = 1'b1;
			$error("SXY push did not move entry 2 into entry 1");
		end

	// Gaps in the register map
	unlistedZero: assert property (@(posedge i_clk)
		(i_regId inside {[5'd6:5'd8], [5'd16:5'd27]}) |-> (i_dataOut == '0))
		else begin
			assertFail = 1'b1;
			$error("unlisted register number read nonzero");
		end

	// FIFO empty right out of reset
	resetClear: assert property (@(posedge i_clk)
		$rose(i_rstN) |-> (i_sxy[0] == '0 && i_sxy[1] == '0 && i_sxy[2] == '0))
		else begin
			assertFail = 1'b1;
			$error("SXY FIFO not cleared by reset");
		end

endmodule

bind gteRegFile gteRegFile_sva gteRegFile_sva_inst (
	.i_clk(i_clk), .i_rstN(i_rstN), .i_pushSxy(pushSxy), .i_sxy(sxy),
	.i_regId(i_regId), .i_dataOut(o_dataOut)
);

// File: tbClock.sv
// Clock and reset source for the register file testbench
// 10 ns clock, reset held low over the first three rising edges
`timescale 1ns/1ps

module tbClock (
	output logic o_clk,
	output logic o_rstN
);
	initial begin
		o_clk = 1'b0;
		forever #5 o_clk = ~o_clk;   // 10 ns period
	end

	initial begin
		o_rstN = 1'b0;
		repeat (3) @(posedge o_clk);
		#1 o_rstN = 1'b1;            // Released just after the third edge
	end

endmodule

// File: tbGteRegFile.sv
// Testbench of the data register file
// Random writes from a fixed seed, every read compared with a register model
`timescale 1ns/1ps

module tbGteRegFile;
	import gtePkg::*;

	logic        clk, rstN, writeReg;
	regId_t      regId;
	gteWord_t    dataIn, dataOut;
	logic [31:0] mVxy [3], mSxy [3], mLzcs;   // Model state
	logic [15:0] mVz [3], mIr [3];

	tbClock tbClock_inst (.o_clk(clk), .o_rstN(rstN));

	gteRegFile gteRegFile_inst (
		.i_clk(clk), .i_rstN(rstN), .i_writeReg(writeReg), .i_regId(regId),
		.i_dataIn(dataIn), .o_dataOut(dataOut)
	);

	// --------------------------------------------------------------------------
	// Reference model
	// --------------------------------------------------------------------------
	function automatic int leadSigns(input logic [31:0] v);
		int n = 1;                               // Sign bit counts itself
		while (n < 32 && v[31-n] == v[31])
			n++;
		return n;
	endfunction

	function automatic logic [4:0] clip5(input logic [15:0] v);
		if (v[15])
			return 5'd0;
		if (v >= 16'h0F80)
			return 5'd31;
		return v[11:7];
	endfunction

	function automatic rgb15_t expectRgb();
		rgb15_t c;
		c   = '0;
		c.r = clip5(mIr[0]);
		c.g = clip5(mIr[1]);
		c.b = clip5(mIr[2]);
		return c;
	endfunction

	function automatic gteWord_t expectRead(input regId_t id);
		gteWord_t w;
		w = '0;
		case (id)
			RegVxy0, RegVxy1, RegVxy2 : w = mVxy[int'(id) / 2];
			RegVz0, RegVz1, RegVz2    : w = {{16{mVz[int'(id) / 2][15]}}, mVz[int'(id) / 2]};
			RegIr1, RegIr2, RegIr3    : w = {{16{mIr[int'(id) - 9][15]}}, mIr[int'(id) - 9]};
			RegSxy0, RegSxy1, RegSxy2 : w = mSxy[int'(id) - 12];
			RegSxyP                   : w = mSxy[2];
			RegIrgb, RegOrgb          : w.rgb = expectRgb();
			RegLzcs                   : w = mLzcs;
			RegLzcr                   : w = 32'(leadSigns(mLzcs));
			default                   : w = '0;
		endcase
		return w;
	endfunction

	function automatic void modelWrite(input regId_t id, input logic [31:0] d);
		case (id)
			RegVxy0, RegVxy1, RegVxy2 : mVxy[int'(id) / 2] = d;
			RegVz0, RegVz1, RegVz2    : mVz[int'(id) / 2] = d[15:0];
			RegIr1, RegIr2, RegIr3    : mIr[int'(id) - 9] = d[15:0];
			RegSxy0, RegSxy1, RegSxy2 : mSxy[int'(id) - 12] = d;
			RegSxyP : begin
				mSxy[0] = mSxy[1];
				mSxy[1] = mSxy[2];
				mSxy[2] = d;                     // New entry at the top
			end
			RegIrgb : begin
				for (int k = 0; k < 3; k++)
					mIr[k] = {4'b0, d[5*k +: 5], 7'b0};
			end
			RegLzcs : mLzcs = d;
			default : ;                          // Read only or unmapped
		endcase
	endfunction

	// IR value from one of three ranges
	function automatic logic [15:0] randIr();
		case ($urandom_range(2))
			0       : return 16'h8000 | 16'($urandom);           // Negative
			1       : return 16'($urandom_range(16'h7FFF, 16'h0F80));
			default : return 16'($urandom_range(16'h0F7F));
		endcase
	endfunction

	// --------------------------------------------------------------------------
	// Compare and drive tasks
	// --------------------------------------------------------------------------
	task automatic checkWord(input string sigName, input gteWord_t got, input gteWord_t exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s got=%h exp=%h", $time, sigName, got, exp);
			$display("Something failed");
			$fatal(1, "read word mismatch");
		end
	endtask

	task automatic checkRgb(input string sigName, input rgb15_t got, input rgb15_t exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s got=%h exp=%h", $time, sigName, got, exp);
			$display("Something failed");
			$fatal(1, "colour mismatch");
		end
	endtask

	task automatic nextCycle();
		@(posedge clk);
		#1;                                      // Drive off the edge
	endtask

	task automatic writeWord(input regId_t id, input logic [31:0] d);
		nextCycle();
		writeReg = 1'b1;
		regId    = id;
		dataIn   = d;
		nextCycle();                             // Taken at this edge
		writeReg = 1'b0;
		modelWrite(id, d);
	endtask

	task automatic readCheck(input regId_t id);
		nextCycle();
		regId = id;
		#1 checkWord($sformatf("o_dataOut[reg %0d]", id), dataOut, expectRead(id));
	endtask

	task automatic readRgb(input regId_t id);
		nextCycle();
		regId = id;
		#1 checkRgb($sformatf("o_dataOut.rgb[reg %0d]", id), dataOut.rgb, expectRgb());
	endtask

	task automatic readAll();
		for (int i = 0; i < 32; i++)
			readCheck(regId_t'(i));
	endtask

	// --------------------------------------------------------------------------
	// Test sequence
	// --------------------------------------------------------------------------
	initial begin
		int          waitCnt;
		int          num;
		logic [31:0] d;
		void'($urandom(23));
		writeReg = 1'b0;
		regId    = RegVxy0;
		dataIn   = '0;
		mLzcs    = '0;
		for (int k = 0; k < 3; k++) begin
			mVxy[k] = '0;
			mSxy[k] = '0;
			mVz[k]  = '0;
			mIr[k]  = '0;
		end
		waitCnt = 0;
		while (rstN !== 1'b1 && waitCnt < 20) begin
			@(posedge clk);
			waitCnt++;
		end
		if (rstN !== 1'b1) begin
			$display("reset was never released");
			$display("Something failed");
			$fatal(1, "reset timeout");
		end
		readAll();                               // Zeros, LZCR reads 32
		// Plain writes, numbers 0..5 and 9..14
		repeat (40) begin
			num = $urandom_range(11);
			writeWord(regId_t'(num < 6 ? num : num + 3), $urandom);
			readCheck(regId_t'(num < 6 ? num : num + 3));
			readCheck(RegSxyP);
		end
		// Pushes mixed with direct entry writes
		repeat (60) begin
			if ($urandom_range(1))
				writeWord(RegSxyP, $urandom);
			else
				writeWord(regId_t'(12 + $urandom_range(2)), $urandom);
			for (int k = 12; k < 16; k++)
				readCheck(regId_t'(k));
		end
		// Colour expansion
		repeat (10) begin
			writeWord(RegIrgb, $urandom);
			readCheck(RegIr1);
			readCheck(RegIr2);
			readCheck(RegIr3);
			readRgb(RegIrgb);
			readRgb(RegOrgb);
		end
		// Saturation over all three IR ranges
		repeat (30) begin
			for (int k = 0; k < 3; k++)
				writeWord(regId_t'(9 + k), {16'($urandom), randIr()});
			readRgb(RegIrgb);
			readRgb(RegOrgb);
		end
		// Lead count, both edge values then varied run lengths
		for (int n = 0; n < 22; n++) begin
			d = $urandom >> $urandom_range(31);
			if ($urandom_range(1))
				d = ~d;
			if (n == 0)
				d = '0;
			if (n == 1)
				d = '1;
			writeWord(RegLzcs, d);
			readCheck(RegLzcs);
			readCheck(RegLzcr);
		end
		// Read-only and unmapped writes leave state alone
		for (int i = 0; i < 32; i++) begin
			if ((i >= 6 && i <= 8) || (i >= 16 && i <= 27) || i == 29 || i == 31)
				writeWord(regId_t'(i), $urandom);
		end
		readAll();
		if (gteRegFile_inst.gteRegFile_sva_inst.assertFail) begin
			$display("a bound assertion fired during the run");
			$display("Something failed");
			$fatal(1, "assertion failure");
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

// File: src.f
gtePkg.sv
gteWriteDecode.sv
gteVectorRegs.sv
gteScreenFifo.sv
gteIrRegs.sv
gteLeadCount.sv
gteReadMux.sv
gteRegFile.sv
gteRegFile_sva.sv
tbClock.sv
tbGteRegFile.sv
